//--- include/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data memory size in 32-bit words.
`define MEM_WORDS 256

// Cycles from an accepted request to its response valid.
// Must be at least 1.
`define RESP_LATENCY 2

// Data path width.
`define XLEN 32

`endif

//--- hw/mem_stage_pkg.sv
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // Bit 1 flags an error response.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [4:0]       rd;
        logic             gr_we;
        logic [`XLEN-1:0] result;     // Also the memory address.
        logic [`XLEN-1:0] store_data;
        mem_op_e          mem_op;
        logic             csr_we;
        logic [11:0]      csr_addr;
        logic [`XLEN-1:0] csr_wdata;
    } exu_lsu_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [`XLEN-1:0]     addr;
        logic [`XLEN-1:0]     wdata;
        logic [`XLEN/8-1:0]   wstrb;
        logic                 load;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             csr_we;
        logic [`XLEN-1:0] final_result;
        logic             gr_we;
        logic [4:0]       rd;
        logic [11:0]      csr_addr;
        logic [`XLEN-1:0] csr_wdata;
    } lsu_wbu_t;

    typedef struct packed {
        logic             gpr_valid;
        logic             csr_valid;
        logic             stall;
        logic [4:0]       rd;
        logic [11:0]      csr_addr;
        logic [`XLEN-1:0] final_result;
        logic [`XLEN-1:0] csr_wdata;
    } lsu_fwd_t;

    // Upstream bits 6, 5 and 4:0 with the two access faults in between.
    typedef struct packed {
        logic       excp_hi;
        logic       store_fault;
        logic       excp_mid;
        logic       load_fault;
        logic [4:0] excp_lo;
    } lsu_excp_t;

endpackage

//--- hw/lane_align.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module lane_align (
    input  mem_stage_pkg::mem_op_e mem_op_i,
    input  logic [1:0]             addr_lo_i,
    input  logic [`XLEN-1:0]       rdata_i,
    input  logic [`XLEN-1:0]       store_data_i,
    output logic [`XLEN-1:0]       load_data_o,
    output logic [`XLEN-1:0]       wdata_o,
    output logic [`XLEN/8-1:0]     wstrb_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = rdata_i[{addr_lo_i, 3'b000} +: 8]; // Byte at the offset.
    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (mem_op_i)
            mem_stage_pkg::MEM_LB:  load_data_o = {{24{byte_sel[7]}}, byte_sel};
            mem_stage_pkg::MEM_LBU: load_data_o = {24'b0, byte_sel};
            mem_stage_pkg::MEM_LH:  load_data_o = {{16{half_sel[15]}}, half_sel};
            mem_stage_pkg::MEM_LHU: load_data_o = {16'b0, half_sel};
            mem_stage_pkg::MEM_LW:  load_data_o = rdata_i;
            default:                load_data_o = '0;
        endcase
    end

    always_comb begin
        case (mem_op_i)
            mem_stage_pkg::MEM_SB: begin
                wdata_o = {4{store_data_i[7:0]}};
                wstrb_o = 4'b0001 << addr_lo_i;
            end
            mem_stage_pkg::MEM_SH: begin
                wdata_o = {2{store_data_i[15:0]}};
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            mem_stage_pkg::MEM_SW: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b0000; // No lanes for loads.
            end
        endcase
    end

endmodule

//--- hw/lsu.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module lsu (
    input  logic                       clock,
    input  logic                       rst_n_i,
    input  logic                       excp_flush_i,
    input  logic                       mret_flush_i,
    input  logic                       exu_valid_i,
    input  mem_stage_pkg::exu_lsu_t    exu_lsu_i,
    input  logic [6:0]                 exu_excp_i,
    output logic                       lsu_ready_o,
    output mem_stage_pkg::mem_req_t    mem_req_o,
    input  logic [`XLEN-1:0]           rdata_i,
    input  mem_stage_pkg::resp_e       rresp_i,
    input  logic                       rvalid_i,
    output logic                       rready_o,
    input  mem_stage_pkg::resp_e       bresp_i,
    input  logic                       bvalid_i,
    output logic                       bready_o,
    input  logic                       wbu_ready_i,
    output logic                       valid_o,
    output mem_stage_pkg::lsu_wbu_t    lsu_wbu_o,
    output mem_stage_pkg::lsu_excp_t   lsu_excp_o,
    output mem_stage_pkg::lsu_fwd_t    lsu_fwd_o
);

    mem_stage_pkg::exu_lsu_t stage_q;
    logic [6:0]              excp_q;
    logic                    valid_q;
    logic                    owed_q;   // Request issued, response not yet taken.
    logic                    flush;
    logic                    accept;
    logic                    retire;
    logic                    resp_fire;
    logic                    in_is_load;
    logic                    in_is_store;
    logic                    stage_is_load;
    logic                    stage_is_store;
    logic [`XLEN-1:0]        load_data;
    logic [`XLEN-1:0]        st_wdata;
    logic [`XLEN/8-1:0]      st_wstrb;
    logic [`XLEN-1:0]        final_result;

    assign flush = excp_flush_i || mret_flush_i;
    assign in_is_load = exu_lsu_i.mem_op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LH,
        mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_LHU};
    assign in_is_store = exu_lsu_i.mem_op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH,
        mem_stage_pkg::MEM_SW};
    assign stage_is_load = stage_q.mem_op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LH,
        mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_LHU};
    assign stage_is_store = stage_q.mem_op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH,
        mem_stage_pkg::MEM_SW};

    lane_align u_store_lanes (
        .mem_op_i     (exu_lsu_i.mem_op),
        .addr_lo_i    (exu_lsu_i.result[1:0]),
        .rdata_i      ('0),
        .store_data_i (exu_lsu_i.store_data),
        .load_data_o  (),
        .wdata_o      (st_wdata),
        .wstrb_o      (st_wstrb)
    );

    lane_align u_load_lanes (
        .mem_op_i     (stage_q.mem_op),
        .addr_lo_i    (stage_q.result[1:0]),
        .rdata_i      (rdata_i),
        .store_data_i (stage_q.store_data),
        .load_data_o  (load_data),
        .wdata_o      (),
        .wstrb_o      ()
    );

    // A drain after flush keeps ready high until the owed response is gone.
    assign rready_o  = owed_q && stage_is_load && (!valid_q || wbu_ready_i);
    assign bready_o  = owed_q && stage_is_store && (!valid_q || wbu_ready_i);
    assign resp_fire = (rvalid_i && rready_o) || (bvalid_i && bready_o);

    assign valid_o = valid_q && !flush &&
        (!owed_q || (stage_is_load ? rvalid_i : bvalid_i));
    assign retire = valid_o && wbu_ready_i;
    assign lsu_ready_o = !flush && !(owed_q && !valid_q) && (!valid_q || retire);
    assign accept = exu_valid_i && lsu_ready_o;

    always_comb begin
        mem_req_o.valid = accept && (in_is_load || in_is_store);
        mem_req_o.we    = in_is_store;
        mem_req_o.addr  = exu_lsu_i.result;
        mem_req_o.wdata = st_wdata;
        mem_req_o.wstrb = st_wstrb;
        mem_req_o.load  = in_is_load;
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            stage_q <= exu_lsu_i;
            excp_q  <= exu_excp_i;
        end
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            owed_q  <= 1'b0;
        end else begin
            if (flush) begin
                valid_q <= 1'b0;
            end else if (accept) begin
                valid_q <= 1'b1;
            end else if (retire) begin
                valid_q <= 1'b0;
            end
            if (mem_req_o.valid) begin
                owed_q <= 1'b1;
            end else if (resp_fire) begin
                owed_q <= 1'b0;
            end
        end
    end

    assign final_result = stage_is_load ? load_data : stage_q.result;

    assign lsu_excp_o.excp_hi     = excp_q[6];
    assign lsu_excp_o.store_fault = valid_q && stage_is_store && bvalid_i && bresp_i[1];
    assign lsu_excp_o.excp_mid    = excp_q[5];
    assign lsu_excp_o.load_fault  = valid_q && stage_is_load && rvalid_i && rresp_i[1];
    assign lsu_excp_o.excp_lo     = excp_q[4:0];

    assign lsu_wbu_o.pc           = stage_q.pc;
    assign lsu_wbu_o.csr_we       = stage_q.csr_we;
    assign lsu_wbu_o.final_result = final_result;
    assign lsu_wbu_o.gr_we        = stage_q.gr_we;
    assign lsu_wbu_o.rd           = stage_q.rd;
    assign lsu_wbu_o.csr_addr     = stage_q.csr_addr;
    assign lsu_wbu_o.csr_wdata    = stage_q.csr_wdata;

    assign lsu_fwd_o.gpr_valid    = valid_q && stage_q.gr_we && (stage_q.rd != 5'd0);
    assign lsu_fwd_o.csr_valid    = valid_q && stage_q.csr_we;
    assign lsu_fwd_o.stall        = valid_q && !valid_o; // Load data not back yet.
    assign lsu_fwd_o.rd           = stage_q.rd;
    assign lsu_fwd_o.csr_addr     = stage_q.csr_addr;
    assign lsu_fwd_o.final_result = final_result;
    assign lsu_fwd_o.csr_wdata    = stage_q.csr_wdata;

    // Ready only ever meets a response on the channel of the staged access.
    a_resp_channel: assert property (@(posedge clock) disable iff (!rst_n_i)
        !(rready_o && bvalid_i) && !(bready_o && rvalid_i));

    // Only one access outstanding on the memory side.
    a_no_req_while_owed: assert property (@(posedge clock) disable iff (!rst_n_i)
        mem_req_o.valid |-> (!owed_q || resp_fire));

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module data_ram (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  mem_stage_pkg::mem_req_t  mem_req_i,
    output logic [`XLEN-1:0]         rdata_o,
    output mem_stage_pkg::resp_e     rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i,
    output mem_stage_pkg::resp_e     bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i
);

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`RESP_LATENCY + 1);

    logic [`XLEN-1:0]     mem [`MEM_WORDS];
    logic [`XLEN-1:0]     rdata_q;
    mem_stage_pkg::resp_e resp_q;
    logic                 pending_q;
    logic                 write_q;   // Pending response is a write.
    logic [CNT_W-1:0]     cnt_q;
    logic [`XLEN-3:0]     word_addr;
    logic [IDX_W-1:0]     idx;
    logic                 in_range;
    logic                 resp_fire;

    assign word_addr = mem_req_i.addr[`XLEN-1:2];
    assign idx       = mem_req_i.addr[IDX_W+1:2];
    assign in_range  = (word_addr < `MEM_WORDS);

    always_ff @(posedge clock) begin
        if (mem_req_i.valid && mem_req_i.we && in_range) begin
            for (int i = 0; i < `XLEN / 8; i++) begin
                if (mem_req_i.wstrb[i]) begin
                    mem[idx][i*8 +: 8] <= mem_req_i.wdata[i*8 +: 8];
                end
            end
        end
        if (mem_req_i.valid) begin
            resp_q <= in_range ? mem_stage_pkg::RESP_OKAY : mem_stage_pkg::RESP_SLVERR;
            if (mem_req_i.load) begin
                rdata_q <= in_range ? mem[idx] : '0; // Zero on slave error.
            end
        end
    end

    assign resp_fire = (rvalid_o && rready_i) || (bvalid_o && bready_i);

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            write_q   <= 1'b0;
            cnt_q     <= '0;
        end else if (mem_req_i.valid) begin
            pending_q <= 1'b1;
            write_q   <= mem_req_i.we;
            cnt_q     <= CNT_W'(`RESP_LATENCY - 1);
        end else if (resp_fire) begin
            pending_q <= 1'b0;
        end else if (pending_q && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign rvalid_o = pending_q && (cnt_q == '0) && !write_q;
    assign bvalid_o = pending_q && (cnt_q == '0) && write_q;
    assign rdata_o  = rdata_q;
    assign rresp_o  = resp_q;
    assign bresp_o  = resp_q;

    // A new request may only land on the edge that retires the old response.
    a_no_req_while_pending: assert property (@(posedge clock) disable iff (!rst_n_i)
        mem_req_i.valid |-> (!pending_q || resp_fire));

endmodule

//--- hw/mem_stage_top.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                       clock,
    input  logic                       rst_n_i,
    input  logic                       excp_flush_i,
    input  logic                       mret_flush_i,
    input  logic                       exu_valid_i,
    input  mem_stage_pkg::exu_lsu_t    exu_lsu_i,
    input  logic [6:0]                 exu_excp_i,
    output logic                       lsu_ready_o,
    input  logic                       wbu_ready_i,
    output logic                       valid_o,
    output mem_stage_pkg::lsu_wbu_t    lsu_wbu_o,
    output mem_stage_pkg::lsu_excp_t   lsu_excp_o,
    output mem_stage_pkg::lsu_fwd_t    lsu_fwd_o
);

    mem_stage_pkg::mem_req_t mem_req;
    logic [`XLEN-1:0]        rdata;
    mem_stage_pkg::resp_e    rresp;
    mem_stage_pkg::resp_e    bresp;
    logic                    rvalid;
    logic                    rready;
    logic                    bvalid;
    logic                    bready;

    lsu u_lsu (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .excp_flush_i (excp_flush_i),
        .mret_flush_i (mret_flush_i),
        .exu_valid_i  (exu_valid_i),
        .exu_lsu_i    (exu_lsu_i),
        .exu_excp_i   (exu_excp_i),
        .lsu_ready_o  (lsu_ready_o),
        .mem_req_o    (mem_req),
        .rdata_i      (rdata),
        .rresp_i      (rresp),
        .rvalid_i     (rvalid),
        .rready_o     (rready),
        .bresp_i      (bresp),
        .bvalid_i     (bvalid),
        .bready_o     (bready),
        .wbu_ready_i  (wbu_ready_i),
        .valid_o      (valid_o),
        .lsu_wbu_o    (lsu_wbu_o),
        .lsu_excp_o   (lsu_excp_o),
        .lsu_fwd_o    (lsu_fwd_o)
    );

    data_ram u_data_ram (
        .clock     (clock),
        .rst_n_i   (rst_n_i),
        .mem_req_i (mem_req),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

endmodule

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module mem_stage_tb;

    localparam int N_RANDOM   = 600;
    localparam int N_TOTAL    = `MEM_WORDS + N_RANDOM; // Fill stores plus random mix.
    localparam int TIMEOUT_NS = N_TOTAL * (`RESP_LATENCY + 6) * 40;

    typedef struct packed {
        mem_stage_pkg::lsu_wbu_t wbu;
        logic [8:0]              excp;
        logic                    mem_access;
    } expect_t;

    logic                      clock;
    logic                      rst_n_i;
    logic                      excp_flush_i;
    logic                      mret_flush_i;
    logic                      exu_valid_i;
    mem_stage_pkg::exu_lsu_t   exu_lsu_i;
    logic [6:0]                exu_excp_i;
    logic                      lsu_ready_o;
    logic                      wbu_ready_i;
    logic                      valid_o;
    mem_stage_pkg::lsu_wbu_t   lsu_wbu_o;
    mem_stage_pkg::lsu_excp_t  lsu_excp_o;
    mem_stage_pkg::lsu_fwd_t   lsu_fwd_o;

    integer                    seed;
    int                        errors;
    int                        checks;
    int                        retired;
    int                        flushed;
    int                        gen_count;
    int                        age;
    int                        drain;      // Cycles left for a flushed response.
    int                        last_store_word;
    logic                      held;
    logic                      accept_now;
    mem_stage_pkg::lsu_wbu_t   held_wbu;
    mem_stage_pkg::exu_lsu_t   cur;
    logic [6:0]                cur_excp;
    logic [31:0]               shadow [`MEM_WORDS];
    expect_t                   exp_q [$];

    mem_stage_top dut0 (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .excp_flush_i (excp_flush_i),
        .mret_flush_i (mret_flush_i),
        .exu_valid_i  (exu_valid_i),
        .exu_lsu_i    (exu_lsu_i),
        .exu_excp_i   (exu_excp_i),
        .lsu_ready_o  (lsu_ready_o),
        .wbu_ready_i  (wbu_ready_i),
        .valid_o      (valid_o),
        .lsu_wbu_o    (lsu_wbu_o),
        .lsu_excp_o   (lsu_excp_o),
        .lsu_fwd_o    (lsu_fwd_o)
    );

    always #20 clock = ~clock;

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] extend_load(mem_stage_pkg::mem_op_e op, logic [31:0] word,
                                                logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = 16'(word >> (8 * off));
        case (op)
            mem_stage_pkg::MEM_LB:  return {{24{b[7]}}, b};
            mem_stage_pkg::MEM_LBU: return {24'd0, b};
            mem_stage_pkg::MEM_LH:  return {{16{h[15]}}, h};
            mem_stage_pkg::MEM_LHU: return {16'd0, h};
            default:                return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(mem_stage_pkg::mem_op_e op, logic [31:0] old,
                                                logic [1:0] off, logic [31:0] data);
        logic [31:0] mask;
        case (op)
            mem_stage_pkg::MEM_SB: mask = 32'h0000_00ff << (8 * off);
            mem_stage_pkg::MEM_SH: mask = 32'h0000_ffff << (8 * off);
            default:               mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | ((data << (8 * off)) & mask);
    endfunction

    task automatic make_instr(input int index);
        int unsigned            word;
        int unsigned            off;
        mem_stage_pkg::mem_op_e op;
        cur.pc         = 32'h8000_0000 + 32'(index * 4);
        cur.rd         = 5'($random(seed));
        cur.gr_we      = 1'($random(seed));
        cur.store_data = $random(seed);
        cur.csr_we     = 1'($random(seed));
        cur.csr_addr   = 12'($random(seed));
        cur.csr_wdata  = $random(seed);
        cur_excp       = 7'($random(seed));
        off            = 0;
        if (index < `MEM_WORDS) begin
            op   = mem_stage_pkg::MEM_SW; // Fill every word first.
            word = index;
        end else if (last_store_word >= 0 && {$random(seed)} % 2 == 0) begin
            op   = mem_stage_pkg::MEM_LW; // Read back the stored word.
            word = last_store_word;
        end else begin
            op   = mem_stage_pkg::mem_op_e'({$random(seed)} % 9);
            word = {$random(seed)} % `MEM_WORDS;
            if ({$random(seed)} % 8 == 0) begin
                word = `MEM_WORDS + {$random(seed)} % 64;
            end
            if (op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_SB})
                off = {$random(seed)} % 4;
            else if (op inside {mem_stage_pkg::MEM_LH, mem_stage_pkg::MEM_LHU,
                                mem_stage_pkg::MEM_SH})
                off = 2 * ({$random(seed)} % 2);
        end
        cur.mem_op = op;
        cur.result = (op == mem_stage_pkg::MEM_NONE) ? $random(seed) : 32'(word * 4 + off);
        last_store_word = (op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH,
            mem_stage_pkg::MEM_SW} && word < `MEM_WORDS) ? int'(word) : -1;
    endtask

    task automatic accept_instr();
        expect_t     e;
        logic        ld;
        logic        st;
        logic        oor;
        int unsigned idx;
        ld  = cur.mem_op inside {mem_stage_pkg::MEM_LB, mem_stage_pkg::MEM_LH,
            mem_stage_pkg::MEM_LW, mem_stage_pkg::MEM_LBU, mem_stage_pkg::MEM_LHU};
        st  = cur.mem_op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH,
            mem_stage_pkg::MEM_SW};
        oor = (ld || st) && (cur.result[31:2] >= `MEM_WORDS);
        idx = cur.result[31:2];
        e.wbu.pc           = cur.pc;
        e.wbu.csr_we       = cur.csr_we;
        e.wbu.gr_we        = cur.gr_we;
        e.wbu.rd           = cur.rd;
        e.wbu.csr_addr     = cur.csr_addr;
        e.wbu.csr_wdata    = cur.csr_wdata;
        e.wbu.final_result = cur.result;
        if (ld) begin
            e.wbu.final_result = oor ? 32'd0 : extend_load(cur.mem_op, shadow[idx],
                                                           cur.result[1:0]);
        end
        e.excp       = {cur_excp[6], st && oor, cur_excp[5], ld && oor, cur_excp[4:0]};
        e.mem_access = ld || st;
        if (st && !oor) begin
            shadow[idx] = merge_store(cur.mem_op, shadow[idx], cur.result[1:0],
                                      cur.store_data); // Written even if later flushed.
        end
        exp_q.push_back(e);
    endtask

    task automatic observe_cycle();
        expect_t front;
        logic    flush_now;
        logic    exp_valid;
        logic    exp_ready;
        flush_now  = excp_flush_i || mret_flush_i;
        accept_now = exu_valid_i && lsu_ready_o;
        exp_ready  = !flush_now && drain == 0;
        if (held && !flush_now) begin
            compare_value("valid_o held", 1, valid_o);
            compare_value("wb bundle held", held_wbu, lsu_wbu_o);
        end
        held     = valid_o && !wbu_ready_i && !flush_now;
        held_wbu = lsu_wbu_o;
        if (exp_q.size() != 0) begin
            front = exp_q[0];
            age++;
            exp_valid = !flush_now && age >= (front.mem_access ? `RESP_LATENCY : 1);
            exp_ready = exp_valid && wbu_ready_i;
            compare_value("valid_o", exp_valid, valid_o);
            compare_value("fwd gpr_valid", front.wbu.gr_we && front.wbu.rd != 5'd0,
                          lsu_fwd_o.gpr_valid);
            compare_value("fwd csr_valid", front.wbu.csr_we, lsu_fwd_o.csr_valid);
            compare_value("fwd stall", !exp_valid, lsu_fwd_o.stall);
            compare_value("fwd rd", front.wbu.rd, lsu_fwd_o.rd);
            compare_value("fwd csr_addr", front.wbu.csr_addr, lsu_fwd_o.csr_addr);
            compare_value("fwd csr_wdata", front.wbu.csr_wdata, lsu_fwd_o.csr_wdata);
            if (exp_valid) begin
                compare_value("fwd result", front.wbu.final_result, lsu_fwd_o.final_result);
            end
            if (valid_o && wbu_ready_i) begin
                compare_value("wb bundle", front.wbu, lsu_wbu_o);
                compare_value("fault bits", front.excp, lsu_excp_o);
                void'(exp_q.pop_front());
                retired++;
            end else if (flush_now) begin
                void'(exp_q.pop_front()); // Dropped, must never retire.
                flushed++;
                if (front.mem_access) begin
                    drain = (age < `RESP_LATENCY) ? `RESP_LATENCY - age : int'(!wbu_ready_i);
                end
            end
        end else begin
            compare_value("fwd idle", 0, {lsu_fwd_o.gpr_valid, lsu_fwd_o.csr_valid,
                                          lsu_fwd_o.stall});
            if (valid_o) begin
                report_error("valid_o is high with no instruction in the stage");
            end
            if (drain > 0) begin
                drain--;
            end
        end
        compare_value("lsu_ready_o", exp_ready, lsu_ready_o);
        if (accept_now) begin
            accept_instr();
            age = 0;
        end
    endtask

    task automatic drive_cycle();
        wbu_ready_i  = ({$random(seed)} % 4 != 0);
        excp_flush_i = ({$random(seed)} % 24 == 0);
        mret_flush_i = ({$random(seed)} % 24 == 0);
        if (accept_now) begin
            exu_valid_i = 1'b0;
        end
        if (!exu_valid_i && gen_count < N_TOTAL && {$random(seed)} % 4 != 0) begin
            make_instr(gen_count);
            gen_count++;
            exu_valid_i = 1'b1;
        end
        exu_lsu_i  = cur;
        exu_excp_i = cur_excp;
    endtask

    initial begin
        seed            = 32'h9112;
        clock           = 1'b0;
        rst_n_i         = 1'b0;
        excp_flush_i    = 1'b0;
        mret_flush_i    = 1'b0;
        exu_valid_i     = 1'b0;
        exu_lsu_i       = '0;
        exu_excp_i      = '0;
        wbu_ready_i     = 1'b0;
        cur             = '0;
        cur_excp        = '0;
        errors          = 0;
        checks          = 0;
        retired         = 0;
        flushed         = 0;
        gen_count       = 0;
        age             = 0;
        drain           = 0;
        last_store_word = -1;
        held            = 1'b0;
        accept_now      = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        rst_n_i = 1'b1;
        while (!(gen_count == N_TOTAL && !exu_valid_i && exp_q.size() == 0)) begin
            @(negedge clock);
            observe_cycle();
            @(posedge clock);
            #2;
            drive_cycle();
        end
        $display("Checks: %0d  errors: %0d  retired: %0d  flushed: %0d",
                 checks, errors, retired, flushed);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired before all instructions retired or flushed");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hw/mem_stage_pkg.sv
hw/lane_align.sv
hw/lsu.sv
hw/data_ram.sv
hw/mem_stage_top.sv
bench/mem_stage_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_stage_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
